// ==== design/access_ctrl.sv ====
`timescale 1ns/10ps

module access_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    // Command queue side
    input  logic                              cmd_empty,
    input  regmem_pkg::cmd_t                  cmd_head,
    output logic                              cmd_pop,
    output logic                              cmd_credit,
    // Memory side
    output logic                              mem_req_valid,
    output regmem_pkg::mem_req_t              mem_req,
    input  logic                              mem_req_ready,
    input  logic                              mem_ack_valid,
    output logic                              mem_ack_ready,
    input  logic [regmem_pkg::DATA_WIDTH-1:0] mem_rd_data,
    // Response queue side
    input  logic                              resp_full,
    output logic                              resp_push,
    output regmem_pkg::resp_t                 resp_push_data,
    input  logic                              resp_empty,
    output logic                              resp_pop,
    output logic                              resp_valid,
    input  logic                              resp_credit
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQUEST,
        S_WAIT_ACK,
        S_RESPOND
    } state_e;

    state_e state;
    state_e state_next;

    // Command being served
    regmem_pkg::cmd_t cmd_q;

    logic [regmem_pkg::RESP_CNT_WIDTH-1:0] credit_cnt;

    logic addr_ok;
    logic read_q;

    // In range when the bits above the memory index are clear
    assign addr_ok = (cmd_head.addr[regmem_pkg::ADDR_WIDTH-1:regmem_pkg::MEM_ADDR_WIDTH] == '0);
    assign read_q  = (cmd_q.op == regmem_pkg::OP_READ);

    // A free response slot is reserved before taking a command
    assign cmd_pop = (state == S_IDLE) && !cmd_empty && !resp_full;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (cmd_pop) begin
                    state_next = addr_ok ? S_REQUEST : S_RESPOND;
                end
            end
            S_REQUEST: begin
                if (mem_req_ready) begin
                    state_next = S_WAIT_ACK;
                end
            end
            S_WAIT_ACK: begin
                if (mem_ack_valid) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            cmd_credit <= 1'b0;
        end else begin
            state      <= state_next;
            cmd_credit <= cmd_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cmd_q <= cmd_head;
        end
    end

    // Memory request, index truncated from the checked address
    assign mem_req_valid = (state == S_REQUEST);
    assign mem_req.write = (cmd_q.op == regmem_pkg::OP_WRITE);
    assign mem_req.idx   = cmd_q.addr[regmem_pkg::MEM_ADDR_WIDTH-1:0];
    assign mem_req.wdata = cmd_q.wdata;
    assign mem_ack_ready = (state == S_WAIT_ACK);

    // Memory responses push on the acknowledge, errors from S_RESPOND
    assign resp_push = ((state == S_WAIT_ACK) && mem_ack_valid) || (state == S_RESPOND);

    assign resp_push_data.tag    = cmd_q.tag;
    assign resp_push_data.op     = cmd_q.op;
    assign resp_push_data.status = (state == S_RESPOND) ? regmem_pkg::ST_ADDR_ERR
                                                        : regmem_pkg::ST_OK;
    assign resp_push_data.rdata  = ((state == S_WAIT_ACK) && read_q) ? mem_rd_data : '0;

    // Delivery to the host needs a credit and a queued response
    assign resp_valid = (credit_cnt != '0) && !resp_empty;
    assign resp_pop   = resp_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= regmem_pkg::RESP_CNT_WIDTH'(regmem_pkg::RESP_CREDITS);
        end else begin
            case ({resp_credit, resp_pop})
                2'b10:   credit_cnt <= credit_cnt + regmem_pkg::RESP_CNT_WIDTH'(1);
                2'b01:   credit_cnt <= credit_cnt - regmem_pkg::RESP_CNT_WIDTH'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== design/credit_fifo.sv ====
`timescale 1ns/10ps

module credit_fifo #(
    parameter type payload_t = regmem_pkg::cmd_t,
    parameter int  DEPTH     = regmem_pkg::CMD_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    // Storage slots
    payload_t slots [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic do_push;
    logic do_pop;

    // Requests beyond capacity or on an empty queue are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == cnt_t'(DEPTH));

    // Head entry is visible whenever the queue holds data
    assign pop_data = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            // Occupancy holds when push and pop coincide
            case ({do_push, do_pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/ext_mem.sv ====
`timescale 1ns/10ps

module ext_mem (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  regmem_pkg::mem_req_t              req,
    output logic                              ack_valid,
    input  logic                              ack_ready,
    output logic [regmem_pkg::DATA_WIDTH-1:0] rd_data
);

    // Word array
    logic [regmem_pkg::DATA_WIDTH-1:0] mem [regmem_pkg::MEM_ENTRIES];

    // Captured request
    regmem_pkg::mem_req_t req_q;

    // Set between acceptance and the array access
    logic pending;

    logic accept;

    // Only one access outstanding at a time
    assign req_ready = !pending && !ack_valid;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // Array access one edge after acceptance
    always_ff @(posedge clk) begin
        if (pending && req_q.write) begin
            mem[req_q.idx] <= req_q.wdata;
        end
    end

    // Read data stays as is on a write
    always_ff @(posedge clk) begin
        if (pending && !req_q.write) begin
            rd_data <= mem[req_q.idx];
        end
    end

    // Handshake sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            ack_valid <= 1'b0;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end else if (pending) begin
                pending   <= 1'b0;
                ack_valid <= 1'b1;
            end else if (ack_valid && ack_ready) begin
                // Acknowledge held until the controller takes it
                ack_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== design/regmem_pkg.sv ====
package regmem_pkg;

    // Data and address sizing
    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 8;
    localparam int MEM_ADDR_WIDTH = 6;
    localparam int MEM_ENTRIES    = 1 << MEM_ADDR_WIDTH;

    // Queue depths and credit budget
    localparam int CMD_DEPTH    = 4;
    localparam int RESP_DEPTH   = 4;
    localparam int RESP_CREDITS = 4;

    // Counter must hold the full credit budget
    localparam int RESP_CNT_WIDTH = $clog2(RESP_CREDITS + 1);

    // Tag echoed back with every response
    localparam int TAG_WIDTH = 4;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    typedef enum logic {
        ST_OK       = 1'b0,
        ST_ADDR_ERR = 1'b1
    } status_e;

    // Host command
    typedef struct packed {
        op_e                   op;
        logic [TAG_WIDTH-1:0]  tag;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } cmd_t;

    // Host response, rdata is zero for writes and errors
    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        op_e                   op;
        status_e               status;
        logic [DATA_WIDTH-1:0] rdata;
    } resp_t;

    // Request from the controller to the memory block
    typedef struct packed {
        logic                      write;
        logic [MEM_ADDR_WIDTH-1:0] idx;
        logic [DATA_WIDTH-1:0]     wdata;
    } mem_req_t;

endpackage

// ==== design/regmem_top.sv ====
`timescale 1ns/10ps

module regmem_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  regmem_pkg::cmd_t  cmd,
    output logic              cmd_credit,
    output logic              resp_valid,
    output regmem_pkg::resp_t resp,
    input  logic              resp_credit
);

    regmem_pkg::cmd_t     cmd_head;
    logic                 cmd_empty;
    logic                 cmd_pop;

    regmem_pkg::resp_t    resp_push_data;
    logic                 resp_push;
    logic                 resp_pop;
    logic                 resp_empty;
    logic                 resp_full;

    regmem_pkg::mem_req_t mem_req;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    logic                 mem_ack_valid;
    logic                 mem_ack_ready;

    logic [regmem_pkg::DATA_WIDTH-1:0] mem_rd_data;

    // Host credits keep this queue from filling past its depth
    credit_fifo #(
        .payload_t (regmem_pkg::cmd_t),
        .DEPTH     (regmem_pkg::CMD_DEPTH)
    ) u_cmd_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cmd_valid),
        .push_data (cmd),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .empty     (cmd_empty),
        .full      ()
    );

    credit_fifo #(
        .payload_t (regmem_pkg::resp_t),
        .DEPTH     (regmem_pkg::RESP_DEPTH)
    ) u_resp_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (resp_push),
        .push_data (resp_push_data),
        .pop       (resp_pop),
        .pop_data  (resp),
        .empty     (resp_empty),
        .full      (resp_full)
    );

    access_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_empty      (cmd_empty),
        .cmd_head       (cmd_head),
        .cmd_pop        (cmd_pop),
        .cmd_credit     (cmd_credit),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_ack_valid  (mem_ack_valid),
        .mem_ack_ready  (mem_ack_ready),
        .mem_rd_data    (mem_rd_data),
        .resp_full      (resp_full),
        .resp_push      (resp_push),
        .resp_push_data (resp_push_data),
        .resp_empty     (resp_empty),
        .resp_pop       (resp_pop),
        .resp_valid     (resp_valid),
        .resp_credit    (resp_credit)
    );

    ext_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .ack_valid (mem_ack_valid),
        .ack_ready (mem_ack_ready),
        .rd_data   (mem_rd_data)
    );

endmodule

// ==== files.f ====
design/regmem_pkg.sv
design/credit_fifo.sv
design/ext_mem.sv
design/access_ctrl.sv
design/regmem_top.sv
test/regmem_assert.sv
test/regmem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

LOG=sim.log
OBJ_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module regmem_tb --Mdir "$OBJ_DIR" -o regmem_sim -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/regmem_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== test/regmem_assert.sv ====
`timescale 1ns/10ps

module regmem_assert (
    input logic clk,
    input logic rst_n,
    input logic mem_req_valid,
    input logic mem_req_ready,
    input logic resp_valid,
    input logic resp_credit,
    input logic cmd_pop,
    input logic cmd_empty
);

    // Host side count of response credits, kept apart from the controller
    logic [regmem_pkg::RESP_CNT_WIDTH-1:0] host_credits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_credits <= regmem_pkg::RESP_CNT_WIDTH'(regmem_pkg::RESP_CREDITS);
        end else begin
            host_credits <= host_credits + regmem_pkg::RESP_CNT_WIDTH'(resp_credit)
                            - regmem_pkg::RESP_CNT_WIDTH'(resp_valid);
        end
    end

    // Request held until the memory accepts it
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid)
        else $error("mem_req_valid dropped before acceptance");

    resp_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> host_credits != '0)
        else $error("resp_valid raised with no response credit");

    pop_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_pop |-> !cmd_empty)
        else $error("cmd_pop while the command queue is empty");

endmodule

bind access_ctrl regmem_assert u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .resp_valid    (resp_valid),
    .resp_credit   (resp_credit),
    .cmd_pop       (cmd_pop),
    .cmd_empty     (cmd_empty)
);

// ==== test/regmem_tb.sv ====
`timescale 1ns/10ps

module regmem_tb;

    typedef logic [regmem_pkg::TAG_WIDTH-1:0]  tag_t;
    typedef logic [regmem_pkg::ADDR_WIDTH-1:0] addr_t;
    typedef logic [regmem_pkg::DATA_WIDTH-1:0] data_t;

    localparam int RESET_CYCLES = 8;
    localparam int PAIR_CMDS    = 16;
    localparam int RAND_CMDS    = 200;
    localparam int BURST_CMDS   = 32;
    localparam int HOLD_CYCLES  = 60;
    localparam int ERR_CMDS     = (1 << regmem_pkg::ADDR_WIDTH) - regmem_pkg::MEM_ENTRIES;
    // Enough commands to fill both queues and use every response credit
    localparam int HOLD_CMDS    = regmem_pkg::RESP_CREDITS + regmem_pkg::RESP_DEPTH
                                  + regmem_pkg::CMD_DEPTH;
    localparam int TOTAL_CMDS   = 2 * regmem_pkg::MEM_ENTRIES + PAIR_CMDS + ERR_CMDS
                                  + RAND_CMDS + HOLD_CMDS + BURST_CMDS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * TOTAL_CMDS;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cmd_valid;
    regmem_pkg::cmd_t  cmd;
    logic              cmd_credit;
    logic              resp_valid;
    regmem_pkg::resp_t resp;
    logic              resp_credit;

    // Host side view of the memory and of the responses still owed
    data_t             mem_model [regmem_pkg::MEM_ENTRIES];
    regmem_pkg::resp_t exp_q [$];
    int                cmd_sent         = 0;
    int                credits_returned = 0;
    int                resp_count       = 0;
    int                credit_owed      = 0;
    bit                credits_open     = 1'b1;

    regmem_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_credit  (cmd_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    function automatic data_t fill_word(input int idx);
        return 32'h9E37_79B9 ^ (32'(idx) * 32'h0101_0101);
    endfunction

    function automatic regmem_pkg::op_e rand_op();
        return ($urandom_range(1) == 1) ? regmem_pkg::OP_WRITE : regmem_pkg::OP_READ;
    endfunction

    // Reference model, also updates the model array for writes
    function automatic regmem_pkg::resp_t expect_resp(input regmem_pkg::cmd_t c);
        regmem_pkg::resp_t r;
        r.tag    = c.tag;
        r.op     = c.op;
        r.status = regmem_pkg::ST_OK;
        r.rdata  = '0;
        if (int'(c.addr) >= regmem_pkg::MEM_ENTRIES) begin
            r.status = regmem_pkg::ST_ADDR_ERR;
        end else if (c.op == regmem_pkg::OP_WRITE) begin
            mem_model[int'(c.addr)] = c.wdata;
        end else begin
            r.rdata = mem_model[int'(c.addr)];
        end
        return r;
    endfunction

    task automatic compare_resp(input regmem_pkg::resp_t got, input regmem_pkg::resp_t exp);
        if (got !== exp) begin
            $display("error at %0t: response tag %0h op %0d status %0d data %h, %s %0h %0d %0d %h",
                     $time, got.tag, got.op, got.status, got.rdata, "expected",
                     exp.tag, exp.op, exp.status, exp.rdata);
            abort_run();
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Host sends only while it holds a command credit
    task automatic send_cmd(input regmem_pkg::op_e op, input addr_t addr, input data_t wdata);
        regmem_pkg::cmd_t c;
        @(posedge clk);
        while (cmd_sent - credits_returned >= regmem_pkg::CMD_DEPTH) begin
            cmd_valid <= 1'b0;
            @(posedge clk);
        end
        c.op    = op;
        c.tag   = tag_t'(cmd_sent);
        c.addr  = addr;
        c.wdata = wdata;
        cmd_valid <= 1'b1;
        cmd       <= c;
        exp_q.push_back(expect_resp(c));
        cmd_sent++;
    endtask

    task automatic idle_host();
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || credit_owed != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // Response credit return, one pulse per delivered response
    initial begin
        resp_credit <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && credits_open && credit_owed > 0) begin
                resp_credit <= 1'b1;
                credit_owed--;
            end else begin
                resp_credit <= 1'b0;
            end
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (cmd_credit) begin
                credits_returned++;
            end
            if (resp_valid && exp_q.size() == 0) begin
                $display("Response with tag %0h arrived with no command outstanding", resp.tag);
                abort_run();
            end else if (resp_valid) begin
                compare_resp(resp, exp_q.pop_front());
                resp_count++;
                credit_owed++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with responses still missing", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        int rx_mark;
        int cr_mark;
        void'($urandom(32'h5745df06));
        rst_n     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd       <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // Every word written first so that all later reads are defined
        for (int i = 0; i < regmem_pkg::MEM_ENTRIES; i++) begin
            send_cmd(regmem_pkg::OP_WRITE, addr_t'(i), fill_word(i));
        end
        for (int i = 0; i < PAIR_CMDS / 2; i++) begin
            send_cmd(regmem_pkg::OP_WRITE, addr_t'((i * 9 + 3) % 64), $urandom);
            send_cmd(regmem_pkg::OP_READ, addr_t'((i * 9 + 3) % 64), '0);
        end
        for (int a = regmem_pkg::MEM_ENTRIES; a < regmem_pkg::MEM_ENTRIES + ERR_CMDS; a++) begin
            send_cmd((a % 2 == 1) ? regmem_pkg::OP_WRITE : regmem_pkg::OP_READ,
                     addr_t'(a), ~fill_word(a));
        end
        for (int i = 0; i < regmem_pkg::MEM_ENTRIES; i++) begin
            send_cmd(regmem_pkg::OP_READ, addr_t'(i), '0);
        end
        // Random mix, about one in eight out of range
        for (int i = 0; i < RAND_CMDS; i++) begin
            send_cmd(rand_op(), ($urandom_range(7) == 0) ? addr_t'($urandom_range(255, 64))
                                                         : addr_t'($urandom_range(63)), $urandom);
        end
        idle_host();
        wait_drained();
        @(negedge clk);
        credits_open = 1'b0;
        rx_mark = resp_count;
        cr_mark = credits_returned;
        for (int i = 0; i < HOLD_CMDS; i++) begin
            send_cmd(rand_op(), addr_t'($urandom_range(63)), $urandom);
        end
        idle_host();
        repeat (HOLD_CYCLES) @(posedge clk);
        compare_count(resp_count - rx_mark, regmem_pkg::RESP_CREDITS, "responses without credit");
        compare_count(credits_returned - cr_mark,
                      regmem_pkg::RESP_CREDITS + regmem_pkg::RESP_DEPTH, "credits while blocked");
        @(negedge clk);
        credits_open = 1'b1;
        wait_drained();
        for (int i = 0; i < BURST_CMDS; i++) begin
            send_cmd((i % 2 == 1) ? regmem_pkg::OP_READ : regmem_pkg::OP_WRITE,
                     addr_t'(i / 2), $urandom);
        end
        idle_host();
        wait_drained();
        compare_count(credits_returned, cmd_sent, "command credit pulses");
        $display("TEST PASS");
        $finish;
    end

endmodule
